//--- common/bp_lce_req_defines.svh
// ********************
// Widths and mesh geometry of the LCE request transmit path
// Row 0 of the mesh belongs to memory, so CCE tiles start at row 1
// Store data never exceeds BP_MAX_DATA_BYTES
// ********************
`ifndef BP_LCE_REQ_DEFINES_SVH
`define BP_LCE_REQ_DEFINES_SVH

// Message header fields
`define BP_PADDR_WIDTH     40
`define BP_LCE_ID_WIDTH    4
`define BP_CCE_ID_WIDTH    4

// Mesh geometry and coordinates
`define BP_MESH_COLS       4
`define BP_CORD_X_WIDTH    4
`define BP_CORD_Y_WIDTH    4

// Wormhole network
`define BP_NOC_LEN_WIDTH   5  // Holds the flit count minus one
`define BP_NOC_FLIT_WIDTH  64

// Largest store payload in bytes
`define BP_MAX_DATA_BYTES  128

// Ceiling division for elaboration time sizing
`define BP_CDIV(x, y) (((x) + (y) - 1) / (y))

`endif

//--- common/bp_lce_req_pkg.sv
// ********************
// Types of the LCE request path
// Struct fields are listed from the most significant bit down
// ********************
`default_nettype none

`include "bp_lce_req_defines.svh"

package bp_lce_req_pkg;

  // Request kinds sent from the LCE to the CCE
  typedef enum logic [1:0] {
    e_bedrock_req_rd_miss = 2'b00,
    e_bedrock_req_wr_miss = 2'b01,
    e_bedrock_req_uc_rd   = 2'b10,
    e_bedrock_req_uc_wr   = 2'b11  // The only request that carries data
  } bp_bedrock_req_type_e;

  // The code is the log2 of the byte count
  typedef enum logic [2:0] {
    e_bedrock_msg_size_1   = 3'b000,
    e_bedrock_msg_size_2   = 3'b001,
    e_bedrock_msg_size_4   = 3'b010,
    e_bedrock_msg_size_8   = 3'b011,
    e_bedrock_msg_size_16  = 3'b100,
    e_bedrock_msg_size_32  = 3'b101,
    e_bedrock_msg_size_64  = 3'b110,
    e_bedrock_msg_size_128 = 3'b111
  } bp_bedrock_msg_size_e;

  typedef struct packed {
    logic [`BP_CCE_ID_WIDTH-1:0] dst_id;  // Directory that owns the address
    logic [`BP_LCE_ID_WIDTH-1:0] src_id;
  } bp_bedrock_lce_req_payload_s;

  // 53 bits in the default configuration
  typedef struct packed {
    bp_bedrock_req_type_e         msg_type;
    bp_bedrock_msg_size_e         size;
    logic [`BP_PADDR_WIDTH-1:0]   addr;
    bp_bedrock_lce_req_payload_s  payload;
  } bp_bedrock_lce_req_msg_header_s;

  typedef struct packed {
    logic [`BP_CORD_Y_WIDTH-1:0] y;
    logic [`BP_CORD_X_WIDTH-1:0] x;
  } bp_noc_cord_s;

  // The cord sits lowest so routers find it in the first flit
  typedef struct packed {
    bp_bedrock_lce_req_msg_header_s msg_hdr;
    logic [`BP_NOC_LEN_WIDTH-1:0]   len;
    bp_noc_cord_s                   cord;
  } bp_lce_req_wormhole_header_s;

  typedef struct packed {
    logic [`BP_NOC_FLIT_WIDTH-1:0] data;
    logic                          last;  // High on the final flit of a packet
  } bp_noc_flit_s;

endpackage

`default_nettype wire

//--- logic/bp_me_cce_id_to_cord.sv
// ********************
// CCE id to mesh coordinate, purely combinational
// Ids fill the mesh row by row starting at row 1
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "bp_lce_req_defines.svh"

module bp_me_cce_id_to_cord
  import bp_lce_req_pkg::*;
  (
    input  wire logic [`BP_CCE_ID_WIDTH-1:0] cce_id_i,
    output bp_noc_cord_s                     cord_o
  );

  localparam int cols_lp    = `BP_MESH_COLS;
  localparam int max_row_lp = ((1 << `BP_CCE_ID_WIDTH) - 1) / cols_lp + 1;

  // Every id in the id space must land on a coordinate that exists
  if (cols_lp > (1 << `BP_CORD_X_WIDTH)) begin : g_cols_check
    $error("Mesh is wider than the x coordinate can address");
  end
  if (max_row_lp >= (1 << `BP_CORD_Y_WIDTH)) begin : g_rows_check
    $error("Some CCE ids fall outside the rows the y coordinate can address");
  end

  always_comb begin
    cord_o.x = `BP_CORD_X_WIDTH'(cce_id_i % cols_lp);
    cord_o.y = `BP_CORD_Y_WIDTH'(cce_id_i / cols_lp + 1);  // Skip the memory row
  end

endmodule

`default_nettype wire

//--- encode/bp_me_wormhole_packet_encode_lce_req.sv
// ********************
// Forms the wormhole header of an LCE request
// Only uc_wr carries data and its length follows the size field
// Purely combinational, the result is valid in the same cycle
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "bp_lce_req_defines.svh"

module bp_me_wormhole_packet_encode_lce_req
  import bp_lce_req_pkg::*;
  (
    input  wire bp_bedrock_lce_req_msg_header_s lce_req_header_i,
    output bp_lce_req_wormhole_header_s         wh_header_o
  );

  localparam int hdr_width_lp  = $bits(bp_lce_req_wormhole_header_s);
  localparam int flit_width_lp = `BP_NOC_FLIT_WIDTH;
  localparam int len_width_lp  = `BP_NOC_LEN_WIDTH;

  // ********************
  // Packet lengths in flits minus one
  // ********************
  localparam int req_len_lp      = `BP_CDIV(hdr_width_lp, flit_width_lp) - 1;
  localparam int data_len_1_lp   = `BP_CDIV(hdr_width_lp + 1*8, flit_width_lp) - 1;
  localparam int data_len_2_lp   = `BP_CDIV(hdr_width_lp + 2*8, flit_width_lp) - 1;
  localparam int data_len_4_lp   = `BP_CDIV(hdr_width_lp + 4*8, flit_width_lp) - 1;
  localparam int data_len_8_lp   = `BP_CDIV(hdr_width_lp + 8*8, flit_width_lp) - 1;
  localparam int data_len_16_lp  = `BP_CDIV(hdr_width_lp + 16*8, flit_width_lp) - 1;
  localparam int data_len_32_lp  = `BP_CDIV(hdr_width_lp + 32*8, flit_width_lp) - 1;
  localparam int data_len_64_lp  = `BP_CDIV(hdr_width_lp + 64*8, flit_width_lp) - 1;
  localparam int data_len_128_lp = `BP_CDIV(hdr_width_lp + 128*8, flit_width_lp) - 1;

  bp_noc_cord_s cce_cord_li;

  bp_me_cce_id_to_cord router_cord (
    .cce_id_i (lce_req_header_i.payload.dst_id),
    .cord_o   (cce_cord_li)
  );

  always_comb begin
    wh_header_o         = '0;
    wh_header_o.msg_hdr = lce_req_header_i;
    wh_header_o.cord    = cce_cord_li;

    unique case (lce_req_header_i.msg_type)
      e_bedrock_req_uc_wr:
        unique case (lce_req_header_i.size)
          e_bedrock_msg_size_1:   wh_header_o.len = len_width_lp'(data_len_1_lp);
          e_bedrock_msg_size_2:   wh_header_o.len = len_width_lp'(data_len_2_lp);
          e_bedrock_msg_size_4:   wh_header_o.len = len_width_lp'(data_len_4_lp);
          e_bedrock_msg_size_8:   wh_header_o.len = len_width_lp'(data_len_8_lp);
          e_bedrock_msg_size_16:  wh_header_o.len = len_width_lp'(data_len_16_lp);
          e_bedrock_msg_size_32:  wh_header_o.len = len_width_lp'(data_len_32_lp);
          e_bedrock_msg_size_64:  wh_header_o.len = len_width_lp'(data_len_64_lp);
          e_bedrock_msg_size_128: wh_header_o.len = len_width_lp'(data_len_128_lp);
          default:                wh_header_o.len = '0;
        endcase
      default: wh_header_o.len = len_width_lp'(req_len_lp);  // Header only requests
    endcase
  end

  // An unknown size falls to the default arm and would cut the packet to one flit
  always_comb begin
    if (lce_req_header_i.msg_type == e_bedrock_req_uc_wr) begin
      assert (!$isunknown(lce_req_header_i.size))
        else $error("uc_wr request with an unknown size code");
    end
  end

endmodule

`default_nettype wire

//--- encode/bp_me_wormhole_flit_sender.sv
// ********************
// Sends one wormhole packet as back to back flits, lowest bits first
// The network never stalls, so there is no ready input
// v_i must stay low while busy_o is high and is ignored if it does not
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "bp_lce_req_defines.svh"

module bp_me_wormhole_flit_sender
  import bp_lce_req_pkg::*;
  (
    input  wire logic                            clk_i,
    input  wire logic                            reset_i,
    input  wire logic                            v_i,
    input  wire bp_lce_req_wormhole_header_s     wh_header_i,
    input  wire logic [`BP_MAX_DATA_BYTES*8-1:0] data_i,
    output logic                                 busy_o,
    output logic                                 flit_v_o,
    output bp_noc_flit_s                         flit_o
  );

  localparam int flit_width_lp  = `BP_NOC_FLIT_WIDTH;
  localparam int data_width_lp  = `BP_MAX_DATA_BYTES*8;
  localparam int hdr_width_lp   = $bits(bp_lce_req_wormhole_header_s);
  localparam int max_flits_lp   = `BP_CDIV(hdr_width_lp + data_width_lp, flit_width_lp);
  localparam int pkt_width_lp   = max_flits_lp * flit_width_lp;
  localparam int shift_width_lp = $clog2(data_width_lp) + 1;

  logic [shift_width_lp-1:0]    data_bits_li;
  logic [data_width_lp-1:0]     data_li;
  logic [pkt_width_lp-1:0]      pkt_li;
  logic [pkt_width_lp-1:0]      pkt_r;
  logic [`BP_NOC_LEN_WIDTH-1:0] flits_left_r;  // Flits still to go after the current one
  logic                         busy_r;
  logic                         capture;

  assign capture = v_i & ~busy_r;

  // ********************
  // Packet assembly
  // ********************
  always_comb begin
    data_bits_li = '0;
    if (wh_header_i.msg_hdr.msg_type == e_bedrock_req_uc_wr) begin
      data_bits_li = shift_width_lp'(8) << wh_header_i.msg_hdr.size;
    end
    // Bytes above the store size are cleared so the last flit is zero filled
    data_li = data_i & ~({data_width_lp{1'b1}} << data_bits_li);
    pkt_li  = pkt_width_lp'({data_li, wh_header_i});
  end

  // ********************
  // Flit sequencing
  // ********************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r       <= 1'b0;
      flits_left_r <= '0;
    end else if (capture) begin
      busy_r       <= 1'b1;
      flits_left_r <= wh_header_i.len;
    end else if (busy_r) begin
      if (flits_left_r == '0) begin
        busy_r <= 1'b0;  // Last flit goes out this cycle
      end else begin
        flits_left_r <= flits_left_r - 1'b1;
      end
    end
  end

  // Payload register, shifted down one flit per cycle while sending
  always_ff @(posedge clk_i) begin
    if (capture) begin
      pkt_r <= pkt_li;
    end else if (busy_r) begin
      pkt_r <= pkt_r >> flit_width_lp;
    end
  end

  assign busy_o      = busy_r;
  assign flit_v_o    = busy_r;
  assign flit_o.data = pkt_r[flit_width_lp-1:0];
  assign flit_o.last = busy_r & (flits_left_r == '0);

  // The requester has to wait for busy_o to drop
  assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> !busy_o)
    else $error("Request strobe while a packet is still being sent");

  // The encoded length has to cover every header and data bit of the packet
  assert property (@(posedge clk_i) disable iff (reset_i)
    flit_o.last |-> pkt_r[pkt_width_lp-1:flit_width_lp] == '0)
    else $error("Packet bits left over after the last flit");

endmodule

`default_nettype wire

//--- logic/bp_me_lce_req_wh_tx.sv
// ********************
// LCE request transmit path onto the coherence network
// Strobe req_v_i only while busy_o is low
// Latency from strobe to last flit is len+1 cycles
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "bp_lce_req_defines.svh"

module bp_me_lce_req_wh_tx
  import bp_lce_req_pkg::*;
  (
    input  wire logic                            clk_i,
    input  wire logic                            reset_i,
    input  wire logic                            req_v_i,
    input  wire bp_bedrock_lce_req_msg_header_s  req_header_i,
    input  wire logic [`BP_MAX_DATA_BYTES*8-1:0] req_data_i,  // Store data in the low bytes
    output logic                                 busy_o,
    output logic                                 flit_v_o,
    output bp_noc_flit_s                         flit_o
  );

  bp_lce_req_wormhole_header_s wh_header_li;

  // Header encode happens in the strobe cycle
  bp_me_wormhole_packet_encode_lce_req encode (
    .lce_req_header_i (req_header_i),
    .wh_header_o      (wh_header_li)
  );

  bp_me_wormhole_flit_sender sender (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (req_v_i),
    .wh_header_i (wh_header_li),
    .data_i      (req_data_i),
    .busy_o      (busy_o),
    .flit_v_o    (flit_v_o),
    .flit_o      (flit_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// ********************
// Free running testbench clock, starts low
// ********************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real period_ns_p = 8.0
) (
  output logic clk_o
);

  initial clk_o = 1'b0;
  always #(period_ns_p / 2.0) clk_o = ~clk_o;  // Half period per toggle

endmodule

`default_nettype wire

//--- testbench/tb_bp_me_lce_req_wh_tx.sv
// ********************
// Testbench for the LCE request wormhole transmit path
// Requests are strobed as soon as the previous packet ends
// Flits are checked at the falling edge against a reference model
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "bp_lce_req_defines.svh"

module tb_bp_me_lce_req_wh_tx
  import bp_lce_req_pkg::*;
  ();

  localparam int data_bits_lp = `BP_MAX_DATA_BYTES*8;
  localparam int wh_bits_lp   = 66;  // Wormhole header width
  localparam int max_flits_lp = 18;
  localparam int num_tests_lp = 36;
  localparam int uc_wr_len_lp [8] = '{1, 1, 1, 2, 3, 5, 9, 17};

  logic                           clk_i;
  logic                           reset_i;
  logic                           req_v_i;
  bp_bedrock_lce_req_msg_header_s req_header_i;
  logic [data_bits_lp-1:0]        req_data_i;
  logic                           busy_o;
  logic                           flit_v_o;
  bp_noc_flit_s                   flit_o;

  integer seed = 32'h94ea4546;
  int cyc = 0;
  int err_cnt = 0;
  int tests_done = 0;
  int tests_failed = 0;
  int flit_idx = 0;
  bit test_bad = 1'b0;

  // Expected flits of all outstanding packets, oldest first
  logic [63:0] exp_data_q[$];
  bit          exp_last_q[$];
  int          exp_cyc_q[$];
  string       exp_name_q[$];

  tb_clock_gen #(.period_ns_p(8.0)) clock_gen (.clk_o(clk_i));

  bp_me_lce_req_wh_tx UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_v_i      (req_v_i),
    .req_header_i (req_header_i),
    .req_data_i   (req_data_i),
    .busy_o       (busy_o),
    .flit_v_o     (flit_v_o),
    .flit_o       (flit_o)
  );

  always @(posedge clk_i) cyc <= cyc + 1;

  // ********************
  // Reference model
  // ********************
  function automatic int expected_flits(input bp_bedrock_lce_req_msg_header_s hdr,
                                        input logic [data_bits_lp-1:0] data,
                                        output logic [63:0] flits [max_flits_lp]);
    logic [max_flits_lp*64-1:0] pkt;
    logic [4:0]                 len;
    logic [3:0]                 x;
    logic [3:0]                 y;
    int                         nbytes;
    nbytes = 0;
    len    = 5'd1;  // Header alone spans two flits
    if (hdr.msg_type == e_bedrock_req_uc_wr) begin
      nbytes = 1 << hdr.size;
      len    = 5'(uc_wr_len_lp[hdr.size]);
    end
    x   = 4'(hdr.payload.dst_id % `BP_MESH_COLS);
    y   = 4'(hdr.payload.dst_id / `BP_MESH_COLS + 1);  // Row 0 is memory
    pkt = '0;
    pkt[wh_bits_lp-1:0] = {hdr, len, y, x};
    for (int i = 0; i < nbytes*8; i++) pkt[wh_bits_lp + i] = data[i];
    for (int k = 0; k < max_flits_lp; k++) flits[k] = pkt[k*64 +: 64];
    return int'(len) + 1;
  endfunction

  function automatic bp_bedrock_lce_req_msg_header_s random_header(
      input bp_bedrock_req_type_e t, input bp_bedrock_msg_size_e s, input logic [3:0] dst);
    bp_bedrock_lce_req_msg_header_s hdr;
    hdr.msg_type       = t;
    hdr.size           = s;
    hdr.addr           = {8'($random(seed)), 32'($random(seed))};
    hdr.payload.dst_id = dst;
    hdr.payload.src_id = 4'($random(seed));
    return hdr;
  endfunction

  function automatic logic [data_bits_lp-1:0] random_data();
    logic [data_bits_lp-1:0] d;
    for (int w = 0; w < data_bits_lp/32; w++) d[w*32 +: 32] = $random(seed);
    return d;
  endfunction

  task count_error();
    err_cnt++;
    test_bad = 1'b1;
  endtask

  // Waits until the sender can take a request, then strobes it for one cycle
  task automatic send_req(input string name, input bp_bedrock_lce_req_msg_header_s hdr,
                          input logic [data_bits_lp-1:0] data);
    logic [63:0] flits [max_flits_lp];
    int          count;
    int          base;
    @(posedge clk_i);
    while (busy_o && !flit_o.last) @(posedge clk_i);
    base  = cyc;
    count = expected_flits(hdr, data, flits);
    for (int k = 0; k < count; k++) begin
      exp_data_q.push_back(flits[k]);
      exp_last_q.push_back(k == count - 1);
      exp_cyc_q.push_back(base + 2 + k);  // Strobe sits in cycle base+1, the first flit follows
      exp_name_q.push_back(name);
    end
    req_v_i      <= 1'b1;
    req_header_i <= hdr;
    req_data_i   <= data;
    @(posedge clk_i);
    req_v_i <= 1'b0;
  endtask

  // ********************
  // Flit monitor
  // ********************
  always @(negedge clk_i) begin : flit_monitor
    logic [63:0] exp_data;
    bit          exp_last;
    int          exp_cyc;
    string       exp_name;
    if (!reset_i) begin
      assert (busy_o === flit_v_o) else begin
        $display("busy_o and flit_v_o disagree at cycle %0d", cyc);
        err_cnt++;
      end
      if (flit_v_o === 1'b1 && exp_data_q.size() == 0) begin
        $display("Flit sent at cycle %0d with no request outstanding", cyc);
        err_cnt++;
      end else if (exp_data_q.size() != 0 && (flit_v_o === 1'b1 || exp_cyc_q[0] <= cyc)) begin
        exp_data = exp_data_q.pop_front();
        exp_last = exp_last_q.pop_front();
        exp_cyc  = exp_cyc_q.pop_front();
        exp_name = exp_name_q.pop_front();
        if (flit_v_o !== 1'b1) begin
          $display("%s: flit %0d did not arrive by cycle %0d", exp_name, flit_idx, cyc);
          count_error();
        end else begin
          assert (cyc == exp_cyc) else begin
            $display("%s: flit %0d came at cycle %0d instead of %0d",
                     exp_name, flit_idx, cyc, exp_cyc);
            count_error();
          end
          assert (flit_o.data === exp_data) else begin
            $display("MISMATCH %s flit %0d data: expected %h actual %h",
                     exp_name, flit_idx, exp_data, flit_o.data);
            count_error();
          end
          assert (flit_o.last === exp_last) else begin
            $display("MISMATCH %s flit %0d last: expected %0b actual %0b",
                     exp_name, flit_idx, exp_last, flit_o.last);
            count_error();
          end
        end
        if (exp_last) begin
          $display("Test %s: %s", exp_name, test_bad ? "error" : "ok");
          tests_done++;
          if (test_bad) tests_failed++;
          test_bad = 1'b0;
          flit_idx = 0;
        end else begin
          flit_idx++;
        end
      end
    end
  end

  // ********************
  // Stimulus
  // ********************
  initial begin : stimulus
    bp_bedrock_lce_req_msg_header_s hdr;
    logic [data_bits_lp-1:0]        data;
    reset_i      = 1'b1;
    req_v_i      = 1'b0;
    req_header_i = '0;
    req_data_i   = '0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    repeat (6) begin
      @(negedge clk_i);
      assert (busy_o === 1'b0 && flit_v_o === 1'b0) else begin
        $display("Sender active after reset with no request");
        count_error();
      end
    end
    $display("Test idle_after_reset: %s", test_bad ? "error" : "ok");
    tests_done++;
    if (test_bad) tests_failed++;
    test_bad = 1'b0;

    // Header only requests carry random data that must not show up
    for (int t = 0; t < 3; t++) begin
      hdr  = random_header(bp_bedrock_req_type_e'(t),
                           bp_bedrock_msg_size_e'(3'($random(seed))), 4'($random(seed)));
      data = random_data();
      send_req($sformatf("hdr_only_type_%0d", t), hdr, data);
    end
    for (int s = 0; s < 8; s++) begin
      hdr  = random_header(e_bedrock_req_uc_wr, bp_bedrock_msg_size_e'(s), 4'($random(seed)));
      data = random_data();
      send_req($sformatf("uc_wr_size_%0d", 1 << s), hdr, data);
    end
    for (int id = 0; id < 16; id++) begin
      hdr  = random_header(e_bedrock_req_uc_rd, e_bedrock_msg_size_8, 4'(id));
      data = random_data();
      send_req($sformatf("dst_sweep_%0d", id), hdr, data);
    end
    for (int n = 0; n < 8; n++) begin
      hdr  = random_header(bp_bedrock_req_type_e'(2'($random(seed))),
                           bp_bedrock_msg_size_e'(3'($random(seed))), 4'($random(seed)));
      data = random_data();
      send_req($sformatf("random_mix_%0d", n), hdr, data);
    end

    while (exp_data_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);  // Catch stray flits after the final packet
    $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
             tests_done, tests_done - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0 && tests_done == num_tests_lp) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Longest packet is 18 flits, so 20 cycles per test leaves room
  initial begin : watchdog
    repeat (num_tests_lp*20 + 100) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", num_tests_lp*20 + 100);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/bp_lce_req_pkg.sv
logic/bp_me_cce_id_to_cord.sv
encode/bp_me_wormhole_packet_encode_lce_req.sv
encode/bp_me_wormhole_flit_sender.sv
logic/bp_me_lce_req_wh_tx.sv
testbench/tb_clock_gen.sv
testbench/tb_bp_me_lce_req_wh_tx.sv

//--- Makefile
# Verilator build and run for the LCE request wormhole transmit path

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_bp_me_lce_req_wh_tx
RTL_TOP    := bp_me_lce_req_wh_tx
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
